/* common/rvPkg.sv */
`default_nettype none

package rvPkg;

    // --------------------------------------------------
    // Sizes and addresses
    // --------------------------------------------------

    // Data and register width
    localparam int xlen = 32;

    // Memory depths in words
    localparam int instMemWords = 256;
    localparam int dataMemWords = 256;

    // Byte address of the LED port
    localparam logic [xlen-1:0] ledAddr = 32'h0000_0200;

    // Program image for the instruction store
    localparam string programFile = "verif/program.hex";

    // --------------------------------------------------
    // Opcodes and funct3 values
    // --------------------------------------------------

    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    // ALU group, shared by R and I forms
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Branch group
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    // --------------------------------------------------
    // ALU operations
    // --------------------------------------------------

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSlt   = 4'd5,
        aluPassB = 4'd6
    } aluOpType;

    // --------------------------------------------------
    // Instruction word, one view per encoding format
    // --------------------------------------------------

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFormatFields;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFormatFields;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFormatFields;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFormatFields;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFormatFields;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFormatFields;

    typedef union packed {
        rFormatFields rFormat;
        iFormatFields iFormat;
        sFormatFields sFormat;
        bFormatFields bFormat;
        uFormatFields uFormat;
        jFormatFields jFormat;
    } instrWord;

endpackage

`default_nettype wire

/* verilog/controlUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module controlUnit
    import rvPkg::*;
(
    input  instrWord         instr,
    output logic [4:0]       rs1Index,
    output logic [4:0]       rs2Index,
    output logic [4:0]       rdIndex,
    output logic             regWrite,
    output logic             aluSrcImm,
    output logic             memWrite,
    output logic             memToReg,
    output logic             branchEq,
    output logic             branchNe,
    output logic             jump,
    output aluOpType         aluOp,
    output logic [xlen-1:0]  immediate
);

    // Register fields sit at the same place in every format
    assign rs1Index = instr.rFormat.rs1;
    assign rs2Index = instr.rFormat.rs2;
    assign rdIndex  = instr.rFormat.rd;

    // --------------------------------------------------
    // Main decode
    // --------------------------------------------------

    always_comb begin
        // Defaults give a no-op
        regWrite  = 1'b0;
        aluSrcImm = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        branchEq  = 1'b0;
        branchNe  = 1'b0;
        jump      = 1'b0;
        aluOp     = aluAdd;
        immediate = '0;

        case (instr.rFormat.opcode)
            opReg: begin
                regWrite = 1'b1;
                case (instr.rFormat.funct3)
                    // funct7 bit 5 picks SUB over ADD
                    f3AddSub: aluOp = instr.rFormat.funct7[5] ? aluSub : aluAdd;
                    f3Slt:    aluOp = aluSlt;
                    f3Xor:    aluOp = aluXor;
                    f3Or:     aluOp = aluOr;
                    f3And:    aluOp = aluAnd;
                    // Unsupported funct3, no write
                    default:  regWrite = 1'b0;
                endcase
            end

            opImm: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                immediate = {{20{instr.iFormat.imm[11]}}, instr.iFormat.imm};
                case (instr.iFormat.funct3)
                    f3AddSub: aluOp = aluAdd;
                    f3Slt:    aluOp = aluSlt;
                    f3Xor:    aluOp = aluXor;
                    f3Or:     aluOp = aluOr;
                    f3And:    aluOp = aluAnd;
                    default:  regWrite = 1'b0;
                endcase
            end

            opLui: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                // Upper 20 bits, ALU forwards operand B
                aluOp     = aluPassB;
                immediate = {instr.uFormat.imm, 12'b0};
            end

            opLoad: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                memToReg  = 1'b1;
                immediate = {{20{instr.iFormat.imm[11]}}, instr.iFormat.imm};
            end

            opStore: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                immediate = {{20{instr.sFormat.immHi[6]}},
                             instr.sFormat.immHi, instr.sFormat.immLo};
            end

            opBranch: begin
                // Compare by subtraction, zero flag decides
                aluOp     = aluSub;
                branchEq  = (instr.bFormat.funct3 == f3Beq);
                branchNe  = (instr.bFormat.funct3 == f3Bne);
                immediate = {{19{instr.bFormat.imm12}}, instr.bFormat.imm12,
                             instr.bFormat.imm11, instr.bFormat.imm10to5,
                             instr.bFormat.imm4to1, 1'b0};
            end

            opJal: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                immediate = {{11{instr.jFormat.imm20}}, instr.jFormat.imm20,
                             instr.jFormat.imm19to12, instr.jFormat.imm11,
                             instr.jFormat.imm10to1, 1'b0};
            end

            default: begin
                // Unknown opcode, treated as no-op
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/programCounter.sv */
`timescale 1ns/100ps
`default_nettype none

module programCounter
    import rvPkg::*;
(
    input  logic             Clock,
    input  logic             reset,
    input  logic             branchEq,
    input  logic             branchNe,
    input  logic             jump,
    input  logic             zero,
    input  logic [xlen-1:0]  immediate,
    output logic [xlen-1:0]  pc,
    output logic [xlen-1:0]  linkAddr
);

    logic             branchTaken;
    logic [xlen-1:0]  target;
    logic [xlen-1:0]  nextPc;

    // Sequential address, also the JAL link value
    assign linkAddr = pc + 32'd4;

    // Taken on equal for BEQ, on not equal for BNE
    assign branchTaken = (branchEq & zero) | (branchNe & ~zero);

    // PC-relative target for branches and JAL
    assign target = pc + immediate;
    assign nextPc = (branchTaken | jump) ? target : linkAddr;

    // PC register
    always_ff @(posedge Clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
`timescale 1ns/100ps
`default_nettype none

module registerFile
    import rvPkg::*;
(
    input  logic             Clock,
    input  logic             reset,
    input  logic [4:0]       rs1Index,
    input  logic [4:0]       rs2Index,
    input  logic [4:0]       rdIndex,
    input  logic             regWrite,
    input  logic [xlen-1:0]  writeData,
    output logic [xlen-1:0]  rs1Data,
    output logic [xlen-1:0]  rs2Data
);

    // x1 to x31, x0 has no storage
    logic [xlen-1:0] regs [1:31];

    // Write port, cleared and blocked during reset
    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (rdIndex != 5'd0)) begin
            regs[rdIndex] <= writeData;
        end
    end

    // Read ports, x0 reads as zero
    assign rs1Data = (rs1Index == 5'd0) ? '0 : regs[rs1Index];
    assign rs2Data = (rs2Index == 5'd0) ? '0 : regs[rs2Index];

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu
    import rvPkg::*;
(
    input  aluOpType         aluOp,
    input  logic [xlen-1:0]  operandA,
    input  logic [xlen-1:0]  operandB,
    output logic [xlen-1:0]  aluResult,
    output logic             zero
);

    logic [xlen-1:0]  sum;
    logic [xlen-1:0]  difference;
    logic             lessThan;

    assign sum        = operandA + operandB;
    assign difference = operandA - operandB;

    // Signed compare for SLT
    assign lessThan = ($signed(operandA) < $signed(operandB));

    // Equality flag for BEQ and BNE
    assign zero = (difference == '0);

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------

    always_comb begin
        case (aluOp)
            aluAdd:   aluResult = sum;
            aluSub:   aluResult = difference;
            aluAnd:   aluResult = operandA & operandB;
            aluOr:    aluResult = operandA | operandB;
            aluXor:   aluResult = operandA ^ operandB;
            aluSlt:   aluResult = {{(xlen-1){1'b0}}, lessThan};
            // LUI value passes straight through
            aluPassB: aluResult = operandB;
            default:  aluResult = sum;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/instMemory.sv */
`timescale 1ns/100ps
`default_nettype none

module instMemory
    import rvPkg::*;
(
    input  logic [xlen-1:0]  pc,
    output logic [xlen-1:0]  instr
);

    localparam int indexBits = $clog2(instMemWords);

    logic [xlen-1:0]       mem [instMemWords];
    logic [indexBits-1:0]  wordIndex;

    // Program image loaded at start
    initial begin
        $readmemh(programFile, mem);
    end

    // Word address, byte offset dropped
    assign wordIndex = pc[indexBits+1:2];

    // Combinational fetch
    assign instr = mem[wordIndex];

endmodule

`default_nettype wire

/* verilog/dataMemory.sv */
`timescale 1ns/100ps
`default_nettype none

module dataMemory
    import rvPkg::*;
(
    input  logic             Clock,
    input  logic             reset,
    input  logic             memWrite,
    input  logic [xlen-1:0]  addr,
    input  logic [xlen-1:0]  writeData,
    output logic [xlen-1:0]  readData,
    output logic [7:0]       led
);

    localparam int indexBits = $clog2(dataMemWords);

    logic [xlen-1:0]       ram [dataMemWords];
    logic [indexBits-1:0]  wordIndex;
    logic                  ledSelect;

    assign wordIndex = addr[indexBits+1:2];

    // LED port decode
    assign ledSelect = (addr == ledAddr);

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------

    // RAM word, skipped when the LED port is addressed
    always_ff @(posedge Clock) begin
        if (memWrite && !ledSelect) begin
            ram[wordIndex] <= writeData;
        end
    end

    // LED register, low byte of the store data
    always_ff @(posedge Clock) begin
        if (reset) begin
            led <= '0;
        end else if (memWrite && ledSelect) begin
            led <= writeData[7:0];
        end
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------

    // LED value reads back zero-extended
    assign readData = ledSelect ? {{(xlen-8){1'b0}}, led} : ram[wordIndex];

endmodule

`default_nettype wire

/* verilog/riscvSystem.sv */
`timescale 1ns/100ps
`default_nettype none

module riscvSystem
    import rvPkg::*;
(
    input  logic             Clock,
    input  logic             reset,
    output logic [7:0]       led,
    output logic             storeValid,
    output logic [xlen-1:0]  storeAddr,
    output logic [xlen-1:0]  storeData
);

    logic [xlen-1:0]  pc;
    logic [xlen-1:0]  linkAddr;
    logic [xlen-1:0]  instr;
    logic [4:0]       rs1Index;
    logic [4:0]       rs2Index;
    logic [4:0]       rdIndex;
    logic             regWrite;
    logic             aluSrcImm;
    logic             memWrite;
    logic             memToReg;
    logic             branchEq;
    logic             branchNe;
    logic             jump;
    aluOpType         aluOp;
    logic [xlen-1:0]  immediate;
    logic [xlen-1:0]  rs1Data;
    logic [xlen-1:0]  rs2Data;
    logic [xlen-1:0]  operandB;
    logic [xlen-1:0]  aluResult;
    logic             zero;
    logic [xlen-1:0]  readData;
    logic [xlen-1:0]  writeBack;
    logic             memWriteEn;

    // --------------------------------------------------
    // Datapath muxes
    // --------------------------------------------------

    // Operand B, register or immediate
    assign operandB = aluSrcImm ? immediate : rs2Data;

    // Write-back, link first, then load, then ALU
    assign writeBack = jump ? linkAddr : (memToReg ? readData : aluResult);

    // No stores while in reset
    assign memWriteEn = memWrite & ~reset;

    // Store port taps the data-write bus
    assign storeValid = memWriteEn;
    assign storeAddr  = aluResult;
    assign storeData  = rs2Data;

    // --------------------------------------------------
    // Blocks
    // --------------------------------------------------

    programCounter u_programCounter (
        .Clock     (Clock),
        .reset     (reset),
        .branchEq  (branchEq),
        .branchNe  (branchNe),
        .jump      (jump),
        .zero      (zero),
        .immediate (immediate),
        .pc        (pc),
        .linkAddr  (linkAddr)
    );

    instMemory u_instMemory (
        .pc    (pc),
        .instr (instr)
    );

    controlUnit u_controlUnit (
        .instr     (instr),
        .rs1Index  (rs1Index),
        .rs2Index  (rs2Index),
        .rdIndex   (rdIndex),
        .regWrite  (regWrite),
        .aluSrcImm (aluSrcImm),
        .memWrite  (memWrite),
        .memToReg  (memToReg),
        .branchEq  (branchEq),
        .branchNe  (branchNe),
        .jump      (jump),
        .aluOp     (aluOp),
        .immediate (immediate)
    );

    registerFile u_registerFile (
        .Clock     (Clock),
        .reset     (reset),
        .rs1Index  (rs1Index),
        .rs2Index  (rs2Index),
        .rdIndex   (rdIndex),
        .regWrite  (regWrite),
        .writeData (writeBack),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data)
    );

    alu u_alu (
        .aluOp     (aluOp),
        .operandA  (rs1Data),
        .operandB  (operandB),
        .aluResult (aluResult),
        .zero      (zero)
    );

    // Data side, address from the ALU
    dataMemory u_dataMemory (
        .Clock     (Clock),
        .reset     (reset),
        .memWrite  (memWriteEn),
        .addr      (aluResult),
        .writeData (rs2Data),
        .readData  (readData),
        .led       (led)
    );

endmodule

`default_nettype wire

/* verif/riscvChecker.sv */
`timescale 1ns/100ps
`default_nettype none

module riscvChecker
    import rvPkg::*;
(
    input  logic             Clock,
    input  logic             reset,
    input  logic [7:0]       led,
    input  logic             storeValid,
    input  logic [xlen-1:0]  storeAddr,
    input  logic [xlen-1:0]  storeData,
    output int               errorCount,
    output int               storesSeen,
    output int               expectedCount,
    output logic [7:0]       finalLed,
    output logic             allStoresSeen
);

    // Upper bound on executed instructions in the model
    localparam int modelStepLimit = 4096;

    logic [xlen-1:0]  progMem [instMemWords];
    logic [xlen-1:0]  expAddr [$];
    logic [xlen-1:0]  expData [$];
    logic [7:0]       expLed = '0;
    logic             modelReady = 1'b0;
    int               errors = 0;
    int               seenCount = 0;
    int               cyclesOutOfReset = 0;

    assign errorCount    = errors;
    assign storesSeen    = seenCount;
    assign allStoresSeen = modelReady && (seenCount == expectedCount);

    // Sign extend a field of the given width
    function automatic logic [xlen-1:0] signExtend(input logic [xlen-1:0] value, input int bits);
        logic signed [xlen-1:0] shifted;
        shifted = value << (xlen - bits);
        return shifted >>> (xlen - bits);
    endfunction

    // --------------------------------------------------
    // Instruction-set model
    // --------------------------------------------------

    // Runs the program to its self-jump, records stores in order
    function automatic void runModel();
        logic [xlen-1:0]  regs [32];
        logic [xlen-1:0]  dataWords [int];
        logic [xlen-1:0]  pc;
        logic [xlen-1:0]  nextPc;
        logic [xlen-1:0]  imm;
        logic [xlen-1:0]  addr;
        logic [xlen-1:0]  a;
        logic [xlen-1:0]  b;
        logic [xlen-1:0]  result;
        logic [7:0]       ledReg;
        logic             writeRd;
        logic             taken;
        instrWord         iw;

        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        ledReg = '0;
        for (int step = 0; step < modelStepLimit; step++) begin
            iw = progMem[(pc >> 2) % instMemWords];
            a = regs[iw.rFormat.rs1];
            b = regs[iw.rFormat.rs2];
            nextPc = pc + 4;
            writeRd = 1'b0;
            result = '0;
            case (iw.rFormat.opcode)
                opReg: begin
                    writeRd = 1'b1;
                    case (iw.rFormat.funct3)
                        3'b000: result = iw.rFormat.funct7[5] ? (a - b) : (a + b);
                        3'b010: result = ($signed(a) < $signed(b)) ? 1 : 0;
                        3'b100: result = a ^ b;
                        3'b110: result = a | b;
                        3'b111: result = a & b;
                        default: writeRd = 1'b0;
                    endcase
                end
                opImm: begin
                    imm = signExtend(iw.iFormat.imm, 12);
                    writeRd = 1'b1;
                    case (iw.iFormat.funct3)
                        3'b000: result = a + imm;
                        3'b010: result = ($signed(a) < $signed(imm)) ? 1 : 0;
                        3'b100: result = a ^ imm;
                        3'b110: result = a | imm;
                        3'b111: result = a & imm;
                        default: writeRd = 1'b0;
                    endcase
                end
                opLui: begin
                    writeRd = 1'b1;
                    result = iw.uFormat.imm << 12;
                end
                opLoad: begin
                    addr = a + signExtend(iw.iFormat.imm, 12);
                    writeRd = 1'b1;
                    if (addr == ledAddr) begin
                        result = ledReg;
                    end else if (dataWords.exists(int'(addr >> 2))) begin
                        result = dataWords[int'(addr >> 2)];
                    end
                end
                opStore: begin
                    addr = a + signExtend({iw.sFormat.immHi, iw.sFormat.immLo}, 12);
                    expAddr.push_back(addr);
                    expData.push_back(b);
                    // LED port takes the low byte, RAM the whole word
                    if (addr == ledAddr) begin
                        ledReg = b[7:0];
                    end else begin
                        dataWords[int'(addr >> 2)] = b;
                    end
                end
                opBranch: begin
                    imm = signExtend({iw.bFormat.imm12, iw.bFormat.imm11, iw.bFormat.imm10to5,
                                      iw.bFormat.imm4to1, 1'b0}, 13);
                    taken = ((iw.bFormat.funct3 == 3'b000) && (a == b)) ||
                            ((iw.bFormat.funct3 == 3'b001) && (a != b));
                    if (taken) begin
                        nextPc = pc + imm;
                    end
                end
                opJal: begin
                    imm = signExtend({iw.jFormat.imm20, iw.jFormat.imm19to12, iw.jFormat.imm11,
                                      iw.jFormat.imm10to1, 1'b0}, 21);
                    writeRd = 1'b1;
                    result = pc + 4;
                    nextPc = pc + imm;
                end
                default: begin
                end
            endcase
            if (writeRd && (iw.rFormat.rd != 5'd0)) begin
                regs[iw.rFormat.rd] = result;
            end
            // Self-jump marks the end of the program
            if (nextPc == pc) begin
                break;
            end
            pc = nextPc;
        end
        finalLed = ledReg;
    endfunction

    task automatic reportMismatch(input string testName, input int index,
                                  input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
        $display("ERR %s[%0d] expected %08h actual %08h at %0t", testName, index,
                 expected, actual, $time);
        errors++;
    endtask

    initial begin
        $readmemh(programFile, progMem);
        runModel();
        expectedCount = expAddr.size();
        modelReady = 1'b1;
    end

    // --------------------------------------------------
    // Compare process, sampled on the falling edge
    // --------------------------------------------------

    always @(negedge Clock) begin
        if (modelReady) begin
            if (reset === 1'b1) begin
                cyclesOutOfReset = 0;
                expLed = '0;
                if (storeValid !== 1'b0) begin
                    reportMismatch("reset_store_valid", 0, 0, storeValid);
                end
                if (led !== 8'h00) begin
                    reportMismatch("reset_led", 0, 0, led);
                end
            end else begin
                cyclesOutOfReset++;
                // First instruction after reset is never a store
                if ((cyclesOutOfReset == 1) && (storeValid !== 1'b0)) begin
                    reportMismatch("first_cycle_store_valid", 0, 0, storeValid);
                end
                // LED holds the last expected LED store, one cycle late
                if (led !== expLed) begin
                    reportMismatch("led_value", seenCount, expLed, led);
                end
                if (storeValid === 1'b1) begin
                    if (seenCount >= expectedCount) begin
                        $display("Extra store to address %08h with data %08h at %0t",
                                 storeAddr, storeData, $time);
                        errors++;
                    end else begin
                        if (storeAddr !== expAddr[seenCount]) begin
                            reportMismatch("store_addr", seenCount, expAddr[seenCount], storeAddr);
                        end
                        if (storeData !== expData[seenCount]) begin
                            reportMismatch("store_data", seenCount, expData[seenCount], storeData);
                        end
                        if (expAddr[seenCount] == ledAddr) begin
                            expLed = expData[seenCount][7:0];
                        end
                        seenCount++;
                    end
                end else if (storeValid !== 1'b0) begin
                    $display("Store valid is unknown at %0t", $time);
                    errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tbRiscvSystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tbRiscvSystem
    import rvPkg::*;
();

    localparam int halfPeriod = 4;
    localparam int resetCycles = 8;
    // Generous bound on cycles between two stores
    localparam int cyclesPerStore = 180;
    // Quiet cycles after the last store to catch stray stores
    localparam int settleCycles = 16;

    logic             Clock = 1'b0;
    logic             reset;
    logic [7:0]       led;
    logic             storeValid;
    logic [xlen-1:0]  storeAddr;
    logic [xlen-1:0]  storeData;
    int               errorCount;
    int               storesSeen;
    int               expectedCount;
    logic [7:0]       finalLed;
    logic             allStoresSeen;
    int               endErrors;

    // --------------------------------------------------
    // Clock and DUT
    // --------------------------------------------------

    initial begin
        forever begin
            #halfPeriod Clock = ~Clock;
        end
    end

    riscvSystem u_riscvSystem (
        .Clock      (Clock),
        .reset      (reset),
        .led        (led),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    riscvChecker u_riscvChecker (
        .Clock         (Clock),
        .reset         (reset),
        .led           (led),
        .storeValid    (storeValid),
        .storeAddr     (storeAddr),
        .storeData     (storeData),
        .errorCount    (errorCount),
        .storesSeen    (storesSeen),
        .expectedCount (expectedCount),
        .finalLed      (finalLed),
        .allStoresSeen (allStoresSeen)
    );

    // --------------------------------------------------
    // Reset, completion and report
    // --------------------------------------------------

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge Clock);
        reset <= 1'b0;
        wait (allStoresSeen === 1'b1);
        repeat (settleCycles) @(posedge Clock);
        endErrors = 0;
        @(negedge Clock);
        // LED keeps the value of the last LED store
        if (led !== finalLed) begin
            $display("ERR final_led expected %02h actual %02h", finalLed, led);
            endErrors++;
        end
        // Checker counts are stable half a cycle after its compare edge
        @(posedge Clock);
        endErrors += errorCount;
        if (expectedCount == 0) begin
            $display("The reference model found no stores in the program");
            endErrors++;
        end
        $display("Stores seen %0d of %0d, errors %0d", storesSeen, expectedCount, endErrors);
        if (endErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog scaled by the expected store count
    initial begin : watchdog
        int limitCycles;
        repeat (resetCycles) @(posedge Clock);
        limitCycles = (expectedCount + 1) * cyclesPerStore;
        repeat (limitCycles) @(posedge Clock);
        $display("Timeout after %0d cycles, the run hung with %0d of %0d stores seen, errors %0d",
                 limitCycles, storesSeen, expectedCount, errorCount);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/program.hex */
// One RV32I instruction word per line in hex, loaded from word address 0
// Covers ALU and immediate ops, LUI, LW and SW, branches, JAL and the LED port
06400093  // 0x00 addi x1, x0, 100
FF900113  // 0x04 addi x2, x0, -7
002081B3  // 0x08 add  x3, x1, x2
00302023  // 0x0C sw   x3, 0(x0)
40110233  // 0x10 sub  x4, x2, x1
00402223  // 0x14 sw   x4, 4(x0)
0020F2B3  // 0x18 and  x5, x1, x2
0022C333  // 0x1C xor  x6, x5, x2
001363B3  // 0x20 or   x7, x6, x1
00702423  // 0x24 sw   x7, 8(x0)
00112433  // 0x28 slt  x8, x2, x1
0F017493  // 0x2C andi x9, x2, 0x0F0
F004C513  // 0x30 xori x10, x9, -256
00556593  // 0x34 ori  x11, x10, 5
FFB5A613  // 0x38 slti x12, x11, -5
00B02623  // 0x3C sw   x11, 12(x0)
008606B3  // 0x40 add  x13, x12, x8
00D02823  // 0x44 sw   x13, 16(x0)
ABCDE737  // 0x48 lui  x14, 0xABCDE
12370713  // 0x4C addi x14, x14, 0x123
00E02A23  // 0x50 sw   x14, 20(x0)
01402783  // 0x54 lw   x15, 20(x0)
00F02C23  // 0x58 sw   x15, 24(x0)
00208463  // 0x5C beq  x1, x2, +8 not taken
00102E23  // 0x60 sw   x1, 28(x0)
00209463  // 0x64 bne  x1, x2, +8 taken
02202023  // 0x68 sw   x2, 32(x0) skipped
00318463  // 0x6C beq  x3, x3, +8 taken
02302023  // 0x70 sw   x3, 32(x0) skipped
00109463  // 0x74 bne  x1, x1, +8 not taken
0080086F  // 0x78 jal  x16, +8
02202023  // 0x7C sw   x2, 32(x0) skipped
03002023  // 0x80 sw   x16, 32(x0)
20000893  // 0x84 addi x17, x0, 0x200
1A500913  // 0x88 addi x18, x0, 0x1A5
0128A023  // 0x8C sw   x18, 0(x17)
03C00913  // 0x90 addi x18, x0, 0x3C
0128A023  // 0x94 sw   x18, 0(x17)
0000006F  // 0x98 jal  x0, 0

/* flist.f */
common/rvPkg.sv
verilog/controlUnit.sv
verilog/programCounter.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/instMemory.sv
verilog/dataMemory.sv
verilog/riscvSystem.sv
verif/riscvChecker.sv
verif/tbRiscvSystem.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tbRiscvSystem -f flist.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { echo "Compile or run step failed"; exit 1; }
cat sim.log
# Result is judged from the log
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1
